//--- src/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_RESET_PC    32'hbfc0_0000

// Primary opcodes
`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_J        6'b000010
`define MIPS_OP_BEQ      6'b000100
`define MIPS_OP_BNE      6'b000101
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_LUI      6'b001111
`define MIPS_OP_LW       6'b100011
`define MIPS_OP_SW       6'b101011

// SPECIAL funct field
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_SLT      6'b101010

// ALU operations
`define MIPS_ALU_ADD     3'd0
`define MIPS_ALU_SUB     3'd1
`define MIPS_ALU_AND     3'd2
`define MIPS_ALU_OR      3'd3
`define MIPS_ALU_SLT     3'd4
`define MIPS_ALU_LUI     3'd5

`define MIPS_WEN_WORD    4'b1111

`endif

//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // --------------------
    // Datapath types

    // Data word, address or instruction
    typedef logic [31:0] word_t;

    // GPR number
    typedef logic [4:0]  reg_idx_t;

    typedef logic [2:0]  alu_op_t;

    // SRAM byte lanes
    typedef logic [3:0]  byte_en_t;

    // --------------------
    // Operand forwarding

    typedef logic [1:0]  fwd_sel_t;

    // Register file value, memory-stage result, write-back value
    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    input  mips_pkg::word_t inst_sram_rdata,
    output logic            inst_sram_en,
    output mips_pkg::word_t inst_sram_addr,
    output mips_pkg::word_t id_pc,
    output mips_pkg::word_t id_inst,
    output logic            id_valid
);
    import mips_pkg::*;

    word_t pc;
    word_t pc_next;

    assign inst_sram_en = 1'b1;

    // While stalled the decode address goes out again, so the same word returns
    assign inst_sram_addr = stall ? id_pc : pc;
    assign id_inst        = inst_sram_rdata;

    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `MIPS_RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (!stall) begin
                id_valid <= 1'b1;
            end
        end
    end

    // PC of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_sram_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  mips_pkg::word_t    id_pc,
    input  mips_pkg::word_t    id_inst,
    input  logic               id_valid,
    input  logic               wb_we,
    input  mips_pkg::reg_idx_t wb_dst,
    input  mips_pkg::word_t    wb_data,
    input  logic               id_fwd_a,
    input  logic               id_fwd_b,
    input  mips_pkg::word_t    mem_result,
    output mips_pkg::reg_idx_t rs,
    output mips_pkg::reg_idx_t rt,
    output logic               id_is_branch,
    output logic               branch_taken,
    output mips_pkg::word_t    branch_target,
    output mips_pkg::word_t    ex_pc,
    output mips_pkg::word_t    ex_a,
    output mips_pkg::word_t    ex_b,
    output mips_pkg::word_t    ex_imm,
    output mips_pkg::alu_op_t  ex_alu_op,
    output logic               ex_use_imm,
    output logic               ex_load,
    output logic               ex_store,
    output logic               ex_we,
    output mips_pkg::reg_idx_t ex_dst,
    output mips_pkg::reg_idx_t ex_rs,
    output mips_pkg::reg_idx_t ex_rt
);
    import mips_pkg::*;

    word_t      regs [32];
    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      rf_a;
    word_t      rf_b;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    word_t      pc_plus4;
    alu_op_t    alu_op;
    reg_idx_t   dst;
    logic       use_imm;
    logic       sign_ext;
    logic       is_load;
    logic       is_store;
    logic       we;
    logic       use_rs;
    logic       use_rt;

    assign opcode = id_inst[31:26];
    assign funct  = id_inst[5:0];

    // --------------------
    // Decoder
    always_comb begin
        alu_op   = `MIPS_ALU_ADD;
        use_imm  = 1'b1;
        sign_ext = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        we       = 1'b0;
        use_rs   = 1'b1;
        use_rt   = 1'b0;
        dst      = id_inst[20:16];
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                use_imm = 1'b0;
                use_rt  = 1'b1;
                dst     = id_inst[15:11];
                we      = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: alu_op = `MIPS_ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = `MIPS_ALU_SUB;
                    `MIPS_FN_AND:  alu_op = `MIPS_ALU_AND;
                    `MIPS_FN_OR:   alu_op = `MIPS_ALU_OR;
                    `MIPS_FN_SLT:  alu_op = `MIPS_ALU_SLT;
                    default:       we     = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: we = 1'b1;
            `MIPS_OP_ORI: begin
                alu_op   = `MIPS_ALU_OR;
                sign_ext = 1'b0;
                we       = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op = `MIPS_ALU_LUI;
                use_rs = 1'b0;
                we     = 1'b1;
            end
            `MIPS_OP_LW: begin
                is_load = 1'b1;
                we      = 1'b1;
            end
            `MIPS_OP_SW: begin
                is_store = 1'b1;
                use_rt   = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE: use_rt = 1'b1;
            default: use_rs = 1'b0;
        endcase
    end

    // Unread source fields go out as r0 so they never match a producer
    assign rs = use_rs ? id_inst[25:21] : 5'd0;
    assign rt = use_rt ? id_inst[20:16] : 5'd0;

    // --------------------
    // Register file, write-back bypassed into the read
    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_dst] <= wb_data;
        end
    end

    assign rf_a = (rs == 5'd0) ? '0 : (wb_we && wb_dst == rs) ? wb_data : regs[rs];
    assign rf_b = (rt == 5'd0) ? '0 : (wb_we && wb_dst == rt) ? wb_data : regs[rt];
    assign op_a = id_fwd_a ? mem_result : rf_a;
    assign op_b = id_fwd_b ? mem_result : rf_b;

    // --------------------
    // Branches and jumps
    assign pc_plus4     = id_pc + 32'd4;
    assign imm          = sign_ext ? {{16{id_inst[15]}}, id_inst[15:0]} : {16'h0000, id_inst[15:0]};
    assign id_is_branch = id_valid && (opcode == `MIPS_OP_BEQ || opcode == `MIPS_OP_BNE);

    always_comb begin
        branch_target = pc_plus4 + {imm[29:0], 2'b00};
        branch_taken  = 1'b0;
        if (id_valid) begin
            case (opcode)
                `MIPS_OP_BEQ: branch_taken = (op_a == op_b);
                `MIPS_OP_BNE: branch_taken = (op_a != op_b);
                `MIPS_OP_J: begin
                    branch_taken  = 1'b1;
                    branch_target = {pc_plus4[31:28], id_inst[25:0], 2'b00};
                end
                default: branch_taken = 1'b0;
            endcase
        end
    end

    // --------------------
    // Decode/execute register
    always_ff @(posedge clk) begin
        if (rst || stall || !id_valid) begin
            ex_we    <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else begin
            ex_we    <= we;
            ex_load  <= is_load;
            ex_store <= is_store;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= id_pc;
        ex_a       <= op_a;
        ex_b       <= op_b;
        ex_imm     <= imm;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
        ex_dst     <= dst;
        ex_rs      <= rs;
        ex_rt      <= rt;
    end

    // Nothing is ever forwarded into r0
    a_decode_r0_zero: assert property (@(posedge clk) disable iff (rst)
        (!stall && id_valid && rs == 5'd0) |=> ex_a == '0);

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    ex_pc,
    input  mips_pkg::word_t    ex_a,
    input  mips_pkg::word_t    ex_b,
    input  mips_pkg::word_t    ex_imm,
    input  mips_pkg::alu_op_t  ex_alu_op,
    input  logic               ex_use_imm,
    input  logic               ex_load,
    input  logic               ex_store,
    input  logic               ex_we,
    input  mips_pkg::reg_idx_t ex_dst,
    input  mips_pkg::fwd_sel_t fwd_a,
    input  mips_pkg::fwd_sel_t fwd_b,
    input  mips_pkg::word_t    wb_data,
    output logic               data_sram_en,
    output mips_pkg::byte_en_t data_sram_wen,
    output mips_pkg::word_t    data_sram_addr,
    output mips_pkg::word_t    data_sram_wdata,
    output mips_pkg::word_t    mem_pc,
    output mips_pkg::word_t    mem_result,
    output logic               mem_load,
    output logic               mem_we,
    output mips_pkg::reg_idx_t mem_dst
);
    import mips_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, ex_a, mem_result, wb_data);
    assign op_b  = fwd_mux(fwd_b, ex_b, mem_result, wb_data);
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            `MIPS_ALU_SUB: alu_result = op_a - alu_b;
            `MIPS_ALU_AND: alu_result = op_a & alu_b;
            `MIPS_ALU_OR:  alu_result = op_a | alu_b;
            `MIPS_ALU_SLT: alu_result = {31'd0, ($signed(op_a) < $signed(alu_b))};
            `MIPS_ALU_LUI: alu_result = {alu_b[15:0], 16'h0000};
            default:       alu_result = op_a + alu_b;
        endcase
    end

    // Request goes out now so load data is back during the memory stage
    assign data_sram_en    = ex_load || ex_store;
    assign data_sram_wen   = ex_store ? `MIPS_WEN_WORD : 4'h0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = op_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_load <= 1'b0;
            mem_we   <= 1'b0;
        end else begin
            mem_load <= ex_load;
            mem_we   <= ex_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc     <= ex_pc;
        mem_result <= alu_result;
        mem_dst    <= ex_dst;
    end

    a_ex_one_access: assert property (@(posedge clk) disable iff (rst)
        !(ex_load && ex_store));

endmodule

`default_nettype wire

//--- src/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    mem_pc,
    input  mips_pkg::word_t    mem_result,
    input  logic               mem_load,
    input  logic               mem_we,
    input  mips_pkg::reg_idx_t mem_dst,
    input  mips_pkg::word_t    data_sram_rdata,
    output mips_pkg::word_t    wb_pc,
    output mips_pkg::word_t    wb_data,
    output logic               wb_we,
    output mips_pkg::reg_idx_t wb_dst
);

    // Register 0 is never written back
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_we && (mem_dst != 5'd0);
        end
    end

    // SRAM word for a load issued in execute lands here
    always_ff @(posedge clk) begin
        wb_pc   <= mem_pc;
        wb_dst  <= mem_dst;
        wb_data <= mem_load ? data_sram_rdata : mem_result;
    end

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  mips_pkg::reg_idx_t rs,
    input  mips_pkg::reg_idx_t rt,
    input  mips_pkg::reg_idx_t ex_rs,
    input  mips_pkg::reg_idx_t ex_rt,
    input  mips_pkg::reg_idx_t ex_dst,
    input  mips_pkg::reg_idx_t mem_dst,
    input  mips_pkg::reg_idx_t wb_dst,
    input  logic               ex_we,
    input  logic               ex_load,
    input  logic               mem_we,
    input  logic               mem_load,
    input  logic               wb_we,
    input  logic               id_is_branch,
    output logic               stall,
    output mips_pkg::fwd_sel_t fwd_a,
    output mips_pkg::fwd_sel_t fwd_b,
    output logic               id_fwd_a,
    output logic               id_fwd_b
);
    import mips_pkg::*;

    logic ex_hit;
    logic mem_load_hit;

    function automatic logic hits(input logic we, input reg_idx_t dst, input reg_idx_t src);
        return we && (dst != 5'd0) && (dst == src);
    endfunction

    // Newest producer wins
    function automatic fwd_sel_t pick(input reg_idx_t src);
        if (hits(mem_we, mem_dst, src)) begin
            return FWD_MEM;
        end else if (hits(wb_we, wb_dst, src)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    // --------------------
    // Stall detection
    assign ex_hit       = hits(ex_we, ex_dst, rs) || hits(ex_we, ex_dst, rt);
    assign mem_load_hit = mem_load && (hits(mem_we, mem_dst, rs) || hits(mem_we, mem_dst, rt));

    // Branches compare in decode, so an execute-stage result is too late
    assign stall = (ex_load && ex_hit) || (id_is_branch && (ex_hit || mem_load_hit));

    // --------------------
    // Forwarding
    assign fwd_a    = pick(ex_rs);
    assign fwd_b    = pick(ex_rt);
    assign id_fwd_a = !mem_load && hits(mem_we, mem_dst, rs);
    assign id_fwd_b = !mem_load && hits(mem_we, mem_dst, rt);

endmodule

`default_nettype wire

//--- src/mycpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mycpu_top (
    input  logic               clk,
    input  logic               rst,

    output logic               inst_sram_en,
    output mips_pkg::byte_en_t inst_sram_wen,
    output mips_pkg::word_t    inst_sram_addr,
    output mips_pkg::word_t    inst_sram_wdata,
    input  mips_pkg::word_t    inst_sram_rdata,

    output logic               data_sram_en,
    output mips_pkg::byte_en_t data_sram_wen,
    output mips_pkg::word_t    data_sram_addr,
    output mips_pkg::word_t    data_sram_wdata,
    input  mips_pkg::word_t    data_sram_rdata,

    output mips_pkg::word_t    debug_wb_pc,
    output mips_pkg::byte_en_t debug_wb_rf_wen,
    output mips_pkg::reg_idx_t debug_wb_rf_wnum,
    output mips_pkg::word_t    debug_wb_rf_wdata
);
    import mips_pkg::*;

    // Fetch and decode
    word_t    id_pc;
    word_t    id_inst;
    logic     id_valid;
    logic     branch_taken;
    word_t    branch_target;
    reg_idx_t rs;
    reg_idx_t rt;
    logic     id_is_branch;

    // Decode/execute register
    word_t    ex_pc;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    alu_op_t  ex_alu_op;
    logic     ex_use_imm;
    logic     ex_load;
    logic     ex_store;
    logic     ex_we;
    reg_idx_t ex_dst;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;

    // Execute/memory and memory/write-back registers
    word_t    mem_pc;
    word_t    mem_result;
    logic     mem_load;
    logic     mem_we;
    reg_idx_t mem_dst;
    word_t    wb_pc;
    word_t    wb_data;
    logic     wb_we;
    reg_idx_t wb_dst;

    // Hazard control
    logic     stall;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     id_fwd_a;
    logic     id_fwd_b;

    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    memory_stage  u_memory  (.*);
    hazard_unit   u_hazard  (.*);

    // Instruction port is read only
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = '0;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_dst;
    assign debug_wb_rf_wdata = wb_data;

endmodule

`default_nettype wire

//--- sim/tb_mycpu.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module tb_mycpu;
    import mips_pkg::*;

    // Five tests of up to 160 instructions at two cycles each, plus reset and drain
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED           = 32'h19e9_e904;
    localparam int NUM_TESTS      = 5;

    logic     clk;
    logic     rst;
    logic     inst_sram_en;
    byte_en_t inst_sram_wen;
    word_t    inst_sram_addr;
    word_t    inst_sram_wdata;
    word_t    inst_sram_rdata;
    logic     data_sram_en;
    byte_en_t data_sram_wen;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata;
    word_t    debug_wb_pc;
    byte_en_t debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t    imem [1024];
    word_t    dmem [1024];

    // Reference state built while a program is assembled
    word_t    prog [$];
    word_t    rf_model [32];
    word_t    dmem_model [word_t];
    int       dead_count;
    logic     delay_slot;
    int       pending_skip;

    word_t    exp_pc [$];
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];
    word_t    st_addr [$];
    word_t    st_data [$];

    int       errors;
    int       tests_failed;
    int       cycles;

    mycpu_top u_mycpu_top (
        .clk               (clk),
        .rst               (rst),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // --------------------
    // SRAM models

    // Store data on enabled byte lanes, old contents elsewhere
    function automatic word_t merge_lanes(input word_t old, input word_t data,
                                          input byte_en_t en);
        word_t mask;
        mask = {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= #1 imem[inst_sram_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_wen != 4'h0) begin
                dmem[data_sram_addr[11:2]] <= merge_lanes(dmem[data_sram_addr[11:2]],
                                                          data_sram_wdata, data_sram_wen);
            end
            data_sram_rdata <= #1 dmem[data_sram_addr[11:2]];
        end
    end

    // --------------------
    // Compare tasks
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Write-back and store monitors
    always @(posedge clk) begin
        if (!rst && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("Unexpected register write to r%0d from pc %h at %0t",
                         debug_wb_rf_wnum, debug_wb_pc, $time);
                errors++;
            end else begin
                check_byte_en("debug_wb_rf_wen", debug_wb_rf_wen, `MIPS_WEN_WORD);
                check_word("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check_reg_idx("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_reg.pop_front());
                check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && data_sram_en && data_sram_wen != 4'h0) begin
            if (st_addr.size() == 0) begin
                $display("Unexpected store to address %h at %0t", data_sram_addr, $time);
                errors++;
            end else begin
                check_word("data_sram_addr", data_sram_addr, st_addr.pop_front());
                check_word("data_sram_wdata", data_sram_wdata, st_data.pop_front());
                check_byte_en("data_sram_wen", data_sram_wen, `MIPS_WEN_WORD);
            end
        end
    end

    // Instruction port never writes
    always @(posedge clk) begin
        if (!rst) begin
            check_byte_en("inst_sram_wen", inst_sram_wen, 4'h0);
            check_word("inst_sram_wdata", inst_sram_wdata, 32'h0000_0000);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the CPU stopped writing back", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------
    // Assembler and reference model
    function automatic word_t encode_r(input logic [5:0] fn, input reg_idx_t rd,
                                       input reg_idx_t rs, input reg_idx_t rt);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input reg_idx_t rt,
                                       input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sign_ext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t arith(input logic [5:0] fn, input word_t a, input word_t b);
        case (fn)
            `MIPS_FN_SUBU: return a - b;
            `MIPS_FN_AND:  return a & b;
            `MIPS_FN_OR:   return a | b;
            `MIPS_FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       return a + b;
        endcase
    endfunction

    // Data memory contents before any store
    function automatic word_t fill_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t next_pc();
        return `MIPS_RESET_PC + word_t'(prog.size() * 4);
    endfunction

    task automatic put_inst(input word_t w);
        prog.push_back(w);
        if (dead_count > 0) begin
            dead_count--;
        end else if (delay_slot) begin
            delay_slot = 1'b0;
            dead_count = pending_skip;
        end
    endtask

    task automatic expect_write(input word_t pc, input reg_idx_t rd, input word_t v);
        if (rd != 5'd0) begin
            rf_model[rd] = v;
            exp_pc.push_back(pc);
            exp_reg.push_back(rd);
            exp_val.push_back(v);
        end
    endtask

    task automatic alu_r(input logic [5:0] fn, input reg_idx_t rd,
                         input reg_idx_t rs, input reg_idx_t rt);
        word_t pc;
        logic  live;
        pc   = next_pc();
        live = (dead_count == 0);
        put_inst(encode_r(fn, rd, rs, rt));
        if (live) begin
            expect_write(pc, rd, arith(fn, rf_model[rs], rf_model[rt]));
        end
    endtask

    task automatic alu_i(input logic [5:0] op, input reg_idx_t rt,
                         input reg_idx_t rs, input logic [15:0] imm);
        word_t pc;
        word_t v;
        logic  live;
        pc   = next_pc();
        live = (dead_count == 0);
        case (op)
            `MIPS_OP_ORI: v = rf_model[rs] | {16'h0000, imm};
            `MIPS_OP_LUI: v = {imm, 16'h0000};
            default:      v = rf_model[rs] + sign_ext(imm);
        endcase
        put_inst(encode_i(op, rt, rs, imm));
        if (live) begin
            expect_write(pc, rt, v);
        end
    endtask

    task automatic store_word(input reg_idx_t rt, input reg_idx_t base, input logic [15:0] off);
        word_t addr;
        addr = rf_model[base] + sign_ext(off);
        if (dead_count == 0) begin
            dmem_model[addr] = rf_model[rt];
            st_addr.push_back(addr);
            st_data.push_back(rf_model[rt]);
        end
        put_inst(encode_i(`MIPS_OP_SW, rt, base, off));
    endtask

    task automatic load_word(input reg_idx_t rt, input reg_idx_t base, input logic [15:0] off);
        word_t pc;
        word_t addr;
        word_t v;
        logic  live;
        pc   = next_pc();
        live = (dead_count == 0);
        addr = rf_model[base] + sign_ext(off);
        v    = dmem_model.exists(addr) ? dmem_model[addr] : fill_word(addr);
        put_inst(encode_i(`MIPS_OP_LW, rt, base, off));
        if (live) begin
            expect_write(pc, rt, v);
        end
    endtask

    // Target lies nskip instructions past the delay slot
    task automatic branch_to(input logic [5:0] op, input reg_idx_t rs,
                             input reg_idx_t rt, input int nskip);
        logic taken;
        taken = (rf_model[rs] == rf_model[rt]) ^ (op == `MIPS_OP_BNE);
        put_inst(encode_i(op, rt, rs, 16'(nskip + 1)));
        delay_slot   = 1'b1;
        pending_skip = taken ? nskip : 0;
    endtask

    task automatic jump_to(input int nskip);
        word_t target;
        target = next_pc() + word_t'((nskip + 2) * 4);
        put_inst({`MIPS_OP_J, target[27:2]});
        delay_slot   = 1'b1;
        pending_skip = nskip;
    endtask

    task automatic start_program();
        prog.delete();
        dmem_model.delete();
        dead_count   = 0;
        delay_slot   = 1'b0;
        pending_skip = 0;
    endtask

    // Marker write, then a jump to itself with a NOP in its delay slot
    task automatic end_program();
        word_t pc;
        alu_i(`MIPS_OP_LUI, 5'd31, 5'd0, 16'hbad0);
        pc = next_pc();
        put_inst({`MIPS_OP_J, pc[27:2]});
        put_inst(32'h0000_0000);
    endtask

    task automatic run_program(input string name);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
            dmem[i] = fill_word(word_t'(i * 4));
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
        if (st_addr.size() != 0) begin
            $display("%s: %0d expected stores never reached the data port", name,
                     st_addr.size());
            errors++;
            st_addr.delete();
            st_data.delete();
        end
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    // --------------------
    // Directed tests
    task automatic test_alu_forwarding();
        start_program();
        alu_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'd5);
        alu_i(`MIPS_OP_ADDIU, 5'd2, 5'd1, 16'd7);
        alu_r(`MIPS_FN_ADDU, 5'd3, 5'd1, 5'd2);
        alu_r(`MIPS_FN_SUBU, 5'd4, 5'd3, 5'd1);
        alu_r(`MIPS_FN_AND, 5'd5, 5'd4, 5'd3);
        alu_r(`MIPS_FN_OR, 5'd6, 5'd5, 5'd2);
        alu_r(`MIPS_FN_SLT, 5'd7, 5'd4, 5'd3);
        alu_i(`MIPS_OP_ADDIU, 5'd8, 5'd0, 16'hfffd);
        alu_r(`MIPS_FN_SLT, 5'd9, 5'd8, 5'd1);
        alu_r(`MIPS_FN_SUBU, 5'd10, 5'd0, 5'd3);
        end_program();
        run_program("alu_forwarding");
    endtask

    task automatic test_store_load();
        start_program();
        alu_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'h0100);
        alu_i(`MIPS_OP_LUI, 5'd2, 5'd0, 16'h1234);
        alu_i(`MIPS_OP_ORI, 5'd2, 5'd2, 16'h5678);
        store_word(5'd2, 5'd1, 16'd4);
        load_word(5'd3, 5'd1, 16'd4);
        alu_r(`MIPS_FN_ADDU, 5'd4, 5'd3, 5'd2);
        store_word(5'd4, 5'd1, 16'd8);
        load_word(5'd5, 5'd1, 16'd8);
        end_program();
        run_program("store_load");
    endtask

    task automatic test_branches();
        start_program();
        alu_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'd3);
        alu_i(`MIPS_OP_ADDIU, 5'd2, 5'd0, 16'd3);
        branch_to(`MIPS_OP_BEQ, 5'd1, 5'd2, 1);
        alu_i(`MIPS_OP_ADDIU, 5'd3, 5'd0, 16'd1);
        alu_i(`MIPS_OP_ADDIU, 5'd4, 5'd0, 16'd2);
        branch_to(`MIPS_OP_BNE, 5'd1, 5'd2, 1);
        alu_i(`MIPS_OP_ADDIU, 5'd5, 5'd0, 16'd3);
        alu_i(`MIPS_OP_ADDIU, 5'd6, 5'd0, 16'd4);
        alu_i(`MIPS_OP_ADDIU, 5'd7, 5'd0, 16'd1);
        branch_to(`MIPS_OP_BNE, 5'd7, 5'd1, 2);
        alu_i(`MIPS_OP_ADDIU, 5'd8, 5'd0, 16'd8);
        alu_i(`MIPS_OP_ADDIU, 5'd9, 5'd0, 16'd9);
        alu_i(`MIPS_OP_ADDIU, 5'd10, 5'd0, 16'd10);
        alu_i(`MIPS_OP_ADDIU, 5'd11, 5'd0, 16'h0200);
        store_word(5'd1, 5'd11, 16'd0);
        load_word(5'd12, 5'd11, 16'd0);
        // Compare straight on the loaded register
        branch_to(`MIPS_OP_BEQ, 5'd12, 5'd1, 1);
        alu_i(`MIPS_OP_ADDIU, 5'd13, 5'd0, 16'd13);
        alu_i(`MIPS_OP_ADDIU, 5'd14, 5'd0, 16'd14);
        branch_to(`MIPS_OP_BEQ, 5'd12, 5'd7, 1);
        alu_i(`MIPS_OP_ADDIU, 5'd15, 5'd0, 16'd15);
        alu_i(`MIPS_OP_ADDIU, 5'd16, 5'd0, 16'd16);
        end_program();
        run_program("branches");
    endtask

    task automatic test_jump_r0();
        start_program();
        alu_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'd1);
        jump_to(2);
        alu_i(`MIPS_OP_ADDIU, 5'd2, 5'd0, 16'd2);
        alu_i(`MIPS_OP_ADDIU, 5'd3, 5'd0, 16'd3);
        alu_i(`MIPS_OP_ADDIU, 5'd4, 5'd0, 16'd4);
        alu_i(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'h1234);
        alu_r(`MIPS_FN_ADDU, 5'd5, 5'd0, 5'd1);
        alu_i(`MIPS_OP_ADDIU, 5'd0, 5'd1, 16'd5);
        alu_r(`MIPS_FN_OR, 5'd6, 5'd0, 5'd1);
        end_program();
        run_program("jump_r0");
    endtask

    task automatic test_random_arith();
        word_t a;
        word_t b;
        start_program();
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            b = $urandom;
            alu_i(`MIPS_OP_LUI, 5'd1, 5'd0, a[31:16]);
            alu_i(`MIPS_OP_ORI, 5'd1, 5'd1, a[15:0]);
            alu_i(`MIPS_OP_LUI, 5'd2, 5'd0, b[31:16]);
            alu_i(`MIPS_OP_ORI, 5'd2, 5'd2, b[15:0]);
            alu_r(`MIPS_FN_ADDU, 5'd3, 5'd1, 5'd2);
            alu_r(`MIPS_FN_SUBU, 5'd4, 5'd1, 5'd2);
            alu_r(`MIPS_FN_SLT, 5'd5, 5'd1, 5'd2);
        end
        end_program();
        run_program("random_arith");
    endtask

    initial begin
        rst             = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        errors          = 0;
        tests_failed    = 0;
        cycles          = 0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        void'($urandom(SEED));
        test_alu_forwarding();
        test_store_load();
        test_branches();
        test_jump_r0();
        test_random_arith();
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/mycpu_top.sv
sim/tb_mycpu.sv

//--- Makefile
obj_dir/Vtb_mycpu: sim.f src/*.sv src/*.svh sim/*.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_mycpu -o Vtb_mycpu

run: obj_dir/Vtb_mycpu
	./obj_dir/Vtb_mycpu | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: run clean
